// ==== verilog/axis_switch_config.svh ====
`ifndef AXIS_SWITCH_CONFIG_SVH
`define AXIS_SWITCH_CONFIG_SVH

// --------------------
// stream widths
// --------------------
`define SW_DATA_WIDTH 8
`define SW_DEST_WIDTH 2

// one frame fifo per dest value.
`define SW_NUM_PORTS 4

// --------------------
// fifo sizing
// --------------------
`define SW_FIFO_ADDR_WIDTH 3

// tuser on the last beat that marks a bad frame.
`define SW_BAD_FRAME_VALUE 1'b1

`endif

// ==== verilog/axis_switch_pkg.sv ====
`include "axis_switch_config.svh"

package axis_switch_pkg;

  // --------------------
  // payload types
  // --------------------
  typedef logic [`SW_DATA_WIDTH-1:0] data_t;
  typedef logic [`SW_DEST_WIDTH-1:0] dest_t;

  // fifo pointer, msb is the wrap bit.
  typedef logic [`SW_FIFO_ADDR_WIDTH:0] ptr_t;

  typedef logic [`SW_NUM_PORTS-1:0] port_mask_t; // one bit per fifo.

  // --------------------
  // output arbiter
  // --------------------
  typedef enum logic {
    MUX_IDLE,  // looking for a fifo with data.
    MUX_FRAME  // passing one frame.
  } mux_state_t;

endpackage

// ==== verilog/axis_dest_demux.sv ====
`timescale 1ns/100ps
`include "axis_switch_config.svh"

module axis_dest_demux (
  // upstream stream
  input  logic [`SW_DATA_WIDTH-1:0] s_tdata,
  input  logic                      s_tvalid,
  input  logic                      s_tlast,
  input  logic [`SW_DEST_WIDTH-1:0] s_tdest,
  input  logic                      s_tuser,
  output logic                      s_tready,

  // fifo array side
  output logic [`SW_DATA_WIDTH-1:0] fifo_tdata,
  output logic [`SW_NUM_PORTS-1:0]  fifo_tvalid,
  output logic                      fifo_tlast,
  output logic                      fifo_tuser,
  input  logic [`SW_NUM_PORTS-1:0]  fifo_tready
);

  logic [`SW_NUM_PORTS-1:0] dest_sel;   // decoded tdest.
  logic [`SW_NUM_PORTS-1:0] ready_hit;  // ready of the addressed fifo only.

  // --------------------
  // tdest decode
  // --------------------
  always_comb begin
    for (int i = 0; i < `SW_NUM_PORTS; i++) begin
      dest_sel[i] = (s_tdest == i[`SW_DEST_WIDTH-1:0]);
    end
  end

  // valid only reaches the selected fifo.
  always_comb begin
    if (s_tvalid) begin
      fifo_tvalid = dest_sel;
    end else begin
      fifo_tvalid = '0;
    end
  end

  // --------------------
  // ready return
  // --------------------
  assign ready_hit = dest_sel & fifo_tready;
  assign s_tready  = |ready_hit;  // zero latency back to the source.

  // payload is shared by all fifos.
  assign fifo_tdata = s_tdata;
  assign fifo_tlast = s_tlast;
  assign fifo_tuser = s_tuser;

endmodule

// ==== verilog/axis_frame_fifo.sv ====
`timescale 1ns/100ps
`include "axis_switch_config.svh"

module axis_frame_fifo (
  input  logic                   clk,
  input  logic                   rst,

  // write side
  input  axis_switch_pkg::data_t s_tdata,
  input  logic                   s_tvalid,
  input  logic                   s_tlast,
  input  logic                   s_tuser,
  output logic                   s_tready,

  // read side
  output axis_switch_pkg::data_t m_tdata,
  output logic                   m_tvalid,
  output logic                   m_tlast,
  input  logic                   m_tready,

  // frame outcome pulses
  output logic                   status_overflow,
  output logic                   status_bad_frame,
  output logic                   status_good_frame
);

  localparam int AW    = `SW_FIFO_ADDR_WIDTH;
  localparam int DEPTH = 2 ** AW;
  localparam axis_switch_pkg::ptr_t PTR_INC = axis_switch_pkg::ptr_t'(1);

  axis_switch_pkg::data_t mem_data [DEPTH];
  logic                   mem_last [DEPTH];

  axis_switch_pkg::ptr_t  wr_ptr;          // committed frames end here.
  axis_switch_pkg::ptr_t  wr_ptr_next;
  axis_switch_pkg::ptr_t  wr_ptr_cur;      // speculative, frame in progress.
  axis_switch_pkg::ptr_t  wr_ptr_cur_next;
  axis_switch_pkg::ptr_t  rd_ptr;
  axis_switch_pkg::ptr_t  rd_ptr_next;

  logic                   wr_en;
  logic                   rd_en;
  logic                   store_output;
  logic                   full_cur;
  logic                   full_wr;
  logic                   empty;

  logic                   drop_frame;
  logic                   drop_frame_next;
  logic                   overflow;
  logic                   overflow_next;
  logic                   bad_frame;
  logic                   bad_frame_next;
  logic                   good_frame;
  logic                   good_frame_next;

  axis_switch_pkg::data_t mem_rd_data;
  logic                   mem_rd_last;
  logic                   mem_rd_valid;
  logic                   mem_rd_valid_next;
  axis_switch_pkg::data_t out_data;
  logic                   out_last;
  logic                   out_valid;
  logic                   out_valid_next;

  assign full_cur = (wr_ptr_cur[AW] != rd_ptr[AW]) &&
                    (wr_ptr_cur[AW-1:0] == rd_ptr[AW-1:0]);
  assign full_wr  = (wr_ptr[AW] != wr_ptr_cur[AW]) &&
                    (wr_ptr[AW-1:0] == wr_ptr_cur[AW-1:0]);
  assign empty    = (wr_ptr == rd_ptr);

  assign s_tready = 1'b1; // drop when full, never stall.

  // --------------------
  // write and commit
  // --------------------
  always_comb begin
    wr_en           = 1'b0;
    drop_frame_next = drop_frame;
    overflow_next   = 1'b0;
    bad_frame_next  = 1'b0;
    good_frame_next = 1'b0;
    wr_ptr_next     = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    if (s_tvalid && s_tready) begin
      if (full_cur || full_wr || drop_frame) begin
        drop_frame_next = 1'b1; // swallow rest of frame.
        if (s_tlast) begin
          wr_ptr_cur_next = wr_ptr;
          drop_frame_next = 1'b0;
          overflow_next   = 1'b1;
        end
      end else begin
        wr_en           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + PTR_INC;
        if (s_tlast) begin
          if (s_tuser == `SW_BAD_FRAME_VALUE) begin
            wr_ptr_cur_next = wr_ptr; // rewind.
            bad_frame_next  = 1'b1;
          end else begin
            wr_ptr_next     = wr_ptr_cur + PTR_INC;
            good_frame_next = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
      overflow   <= 1'b0;
      bad_frame  <= 1'b0;
      good_frame <= 1'b0;
    end else begin
      wr_ptr     <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      drop_frame <= drop_frame_next;
      overflow   <= overflow_next;
      bad_frame  <= bad_frame_next;
      good_frame <= good_frame_next;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_data[wr_ptr_cur[AW-1:0]] <= s_tdata;
      mem_last[wr_ptr_cur[AW-1:0]] <= s_tlast;
    end
  end

  // --------------------
  // read pipeline
  // --------------------
  always_comb begin
    rd_en             = 1'b0;
    rd_ptr_next       = rd_ptr;
    mem_rd_valid_next = mem_rd_valid;
    if (store_output || !mem_rd_valid) begin
      if (!empty) begin
        rd_en             = 1'b1;
        mem_rd_valid_next = 1'b1;
        rd_ptr_next       = rd_ptr + PTR_INC;
      end else begin
        mem_rd_valid_next = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr       <= '0;
      mem_rd_valid <= 1'b0;
    end else begin
      rd_ptr       <= rd_ptr_next;
      mem_rd_valid <= mem_rd_valid_next;
    end
    if (rd_en) begin
      mem_rd_data <= mem_data[rd_ptr[AW-1:0]];
      mem_rd_last <= mem_last[rd_ptr[AW-1:0]];
    end
  end

  // output register moves whenever it is empty or being taken.
  always_comb begin
    store_output   = m_tready || !out_valid;
    out_valid_next = store_output ? mem_rd_valid : out_valid;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= out_valid_next;
    end
    if (store_output) begin
      out_data <= mem_rd_data;
      out_last <= mem_rd_last;
    end
  end

  assign m_tdata  = out_data;
  assign m_tvalid = out_valid;
  assign m_tlast  = out_last;

  assign status_overflow   = overflow;
  assign status_bad_frame  = bad_frame;
  assign status_good_frame = good_frame;

endmodule

// ==== verilog/axis_rr_mux.sv ====
`timescale 1ns/100ps
`include "axis_switch_config.svh"

module axis_rr_mux (
  input  logic                                        clk,
  input  logic                                        rst,

  // fifo side
  input  axis_switch_pkg::data_t [`SW_NUM_PORTS-1:0]  q_tdata,
  input  axis_switch_pkg::port_mask_t                 q_tvalid,
  input  axis_switch_pkg::port_mask_t                 q_tlast,
  output axis_switch_pkg::port_mask_t                 q_tready,

  // merged output
  output axis_switch_pkg::data_t                      m_tdata,
  output logic                                        m_tvalid,
  output logic                                        m_tlast,
  output axis_switch_pkg::dest_t                      m_tdest,
  input  logic                                        m_tready
);

  axis_switch_pkg::mux_state_t state;
  axis_switch_pkg::mux_state_t state_next;
  axis_switch_pkg::dest_t      grant;       // also the last fifo served.
  axis_switch_pkg::dest_t      grant_next;
  axis_switch_pkg::dest_t      pick;
  logic                        found;
  logic                        out_ready;
  logic                        xfer;

  axis_switch_pkg::data_t      out_data;
  axis_switch_pkg::dest_t      out_dest;
  logic                        out_last;
  logic                        out_valid;

  // --------------------
  // round robin search
  // --------------------
  always_comb begin
    axis_switch_pkg::dest_t cand;
    found = 1'b0;
    pick  = grant;
    cand  = grant;
    for (int i = 1; i <= `SW_NUM_PORTS; i++) begin
      cand = axis_switch_pkg::dest_t'(grant + i); // starts after last grant.
      if (!found && q_tvalid[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  assign out_ready = m_tready || !out_valid;
  assign xfer      = (state == axis_switch_pkg::MUX_FRAME) && q_tvalid[grant] && out_ready;

  always_comb begin
    q_tready = '0;
    if (state == axis_switch_pkg::MUX_FRAME) begin
      q_tready[grant] = out_ready;
    end
  end

  // --------------------
  // frame state
  // --------------------
  always_comb begin
    state_next = state;
    grant_next = grant;
    case (state)
      axis_switch_pkg::MUX_IDLE: begin
        if (found) begin
          state_next = axis_switch_pkg::MUX_FRAME;
          grant_next = pick;
        end
      end
      default: begin
        if (xfer && q_tlast[grant]) begin
          state_next = axis_switch_pkg::MUX_IDLE; // frame done.
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= axis_switch_pkg::MUX_IDLE;
      grant     <= '0;
      out_valid <= 1'b0;
    end else begin
      state <= state_next;
      grant <= grant_next;
      if (xfer) begin
        out_valid <= 1'b1;
      end else if (m_tready) begin
        out_valid <= 1'b0;
      end
    end
    if (xfer) begin
      out_data <= q_tdata[grant];
      out_last <= q_tlast[grant];
      out_dest <= grant; // fifo index is the dest.
    end
  end

  assign m_tdata  = out_data;
  assign m_tvalid = out_valid;
  assign m_tlast  = out_last;
  assign m_tdest  = out_dest;

endmodule

// ==== verilog/axis_switch_top.sv ====
`timescale 1ns/100ps
`include "axis_switch_config.svh"

module axis_switch_top (
  input  logic                        clk,
  input  logic                        rst,

  // input stream
  input  axis_switch_pkg::data_t      s_tdata,
  input  logic                        s_tvalid,
  output logic                        s_tready,
  input  logic                        s_tlast,
  input  axis_switch_pkg::dest_t      s_tdest,
  input  logic                        s_tuser,

  // output stream
  output axis_switch_pkg::data_t      m_tdata,
  output logic                        m_tvalid,
  input  logic                        m_tready,
  output logic                        m_tlast,
  output axis_switch_pkg::dest_t      m_tdest,

  // per fifo outcome pulses
  output axis_switch_pkg::port_mask_t status_overflow,
  output axis_switch_pkg::port_mask_t status_bad_frame,
  output axis_switch_pkg::port_mask_t status_good_frame
);

  // --------------------
  // demux to fifos
  // --------------------
  axis_switch_pkg::data_t                     fifo_tdata;
  axis_switch_pkg::port_mask_t                fifo_tvalid;
  logic                                       fifo_tlast;
  logic                                       fifo_tuser;
  axis_switch_pkg::port_mask_t                fifo_tready;

  // --------------------
  // fifos to mux
  // --------------------
  axis_switch_pkg::data_t [`SW_NUM_PORTS-1:0] q_tdata;
  axis_switch_pkg::port_mask_t                q_tvalid;
  axis_switch_pkg::port_mask_t                q_tlast;
  axis_switch_pkg::port_mask_t                q_tready;

  axis_dest_demux demux_i (
    .s_tdata     (s_tdata),
    .s_tvalid    (s_tvalid),
    .s_tlast     (s_tlast),
    .s_tdest     (s_tdest),
    .s_tuser     (s_tuser),
    .s_tready    (s_tready),
    .fifo_tdata  (fifo_tdata),
    .fifo_tvalid (fifo_tvalid),
    .fifo_tlast  (fifo_tlast),
    .fifo_tuser  (fifo_tuser),
    .fifo_tready (fifo_tready)
  );

  for (genvar i = 0; i < `SW_NUM_PORTS; i++) begin : g_fifo
    axis_frame_fifo fifo_i (
      .clk               (clk),
      .rst               (rst),
      .s_tdata           (fifo_tdata),
      .s_tvalid          (fifo_tvalid[i]),
      .s_tlast           (fifo_tlast),
      .s_tuser           (fifo_tuser),
      .s_tready          (fifo_tready[i]),
      .m_tdata           (q_tdata[i]),
      .m_tvalid          (q_tvalid[i]),
      .m_tlast           (q_tlast[i]),
      .m_tready          (q_tready[i]),
      .status_overflow   (status_overflow[i]),
      .status_bad_frame  (status_bad_frame[i]),
      .status_good_frame (status_good_frame[i])
    );
  end

  axis_rr_mux mux_i (
    .clk      (clk),
    .rst      (rst),
    .q_tdata  (q_tdata),
    .q_tvalid (q_tvalid),
    .q_tlast  (q_tlast),
    .q_tready (q_tready),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tlast  (m_tlast),
    .m_tdest  (m_tdest),
    .m_tready (m_tready)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst = 1'b1
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release a little after the edge, like the other inputs.
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

// ==== verif/axis_switch_checker.sv ====
`timescale 1ns/100ps
`include "axis_switch_config.svh"

module axis_switch_checker (
  input  logic                        clk,
  input  logic                        rst,
  input  axis_switch_pkg::data_t      s_tdata,
  input  logic                        s_tvalid,
  input  logic                        s_tready,
  input  logic                        s_tlast,
  input  axis_switch_pkg::dest_t      s_tdest,
  input  logic                        s_tuser,
  input  axis_switch_pkg::data_t      m_tdata,
  input  logic                        m_tvalid,
  input  logic                        m_tready,
  input  logic                        m_tlast,
  input  axis_switch_pkg::dest_t      m_tdest,
  input  axis_switch_pkg::port_mask_t status_overflow,
  input  axis_switch_pkg::port_mask_t status_bad_frame,
  input  axis_switch_pkg::port_mask_t status_good_frame,
  input  logic                        finish_req,
  output logic                        idle,
  output logic                        report_done,
  output int                          error_count
);

  localparam int PORTS = `SW_NUM_PORTS;
  localparam int DEPTH = 2 ** `SW_FIFO_ADDR_WIDTH;

  logic [`SW_DATA_WIDTH:0]     exp_q [PORTS][$];  // {last, data} per dest.
  logic [`SW_DATA_WIDTH:0]     in_beats [$];      // frame being received.
  int                          held_fill [PORTS]; // beats stored while m_tready low.
  int                          good_frames [PORTS];
  int                          good_pulses [PORTS];
  int                          frames_out;
  int                          frames_dropped;
  axis_switch_pkg::port_mask_t exp_ovf;
  axis_switch_pkg::port_mask_t exp_bad;
  axis_switch_pkg::port_mask_t exp_good;
  logic                        out_busy;
  axis_switch_pkg::dest_t      out_dest;
  logic                        stall_seen;
  axis_switch_pkg::data_t      stall_data;

  task automatic check_pulses(input string name, input axis_switch_pkg::port_mask_t got,
                              input axis_switch_pkg::port_mask_t exp);
    for (int p = 0; p < PORTS; p++) begin
      if (exp[p] && !got[p]) begin
        $display("missing %s pulse on port %0d at %0t", name, p, $time);
        error_count++;
      end
    end
    if ((got & ~exp) != '0) begin
      $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, got);
      error_count++;
    end
  endtask

  // --------------------
  // input side model
  // --------------------
  task automatic watch_input();
    int len;
    axis_switch_pkg::dest_t d;
    if (s_tvalid && !s_tready) begin
      // the source is never stalled.
      $display("CHECK FAILED s_tready expected 0x1 got 0x%h", s_tready);
      error_count++;
    end
    if (s_tvalid && s_tready) begin
      in_beats.push_back({s_tlast, s_tdata});
      if (s_tlast) begin
        len = in_beats.size();
        d   = s_tdest;
        if (len > DEPTH || held_fill[d] + len > DEPTH) begin
          exp_ovf[d] = 1'b1;
          frames_dropped++;
        end else if (s_tuser == `SW_BAD_FRAME_VALUE) begin
          exp_bad[d] = 1'b1;
          frames_dropped++;
        end else begin
          exp_good[d] = 1'b1;
          good_frames[d]++;
          foreach (in_beats[i]) exp_q[d].push_back(in_beats[i]);
          if (!m_tready) held_fill[d] += len;
        end
        in_beats.delete();
      end
    end
    if (m_tready) begin
      for (int p = 0; p < PORTS; p++) held_fill[p] = 0; // fifos drain again.
    end
  endtask

  // --------------------
  // output side
  // --------------------
  task automatic watch_output();
    logic [`SW_DATA_WIDTH:0] beat;
    if (stall_seen) begin
      if (!m_tvalid) begin
        $display("m_tvalid dropped at %0t before its beat was taken", $time);
        error_count++;
      end else if (m_tdata != stall_data) begin
        $display("CHECK FAILED m_tdata expected 0x%h got 0x%h", stall_data, m_tdata);
        error_count++;
      end
    end
    stall_seen = m_tvalid && !m_tready;
    stall_data = m_tdata;
    if (m_tvalid && m_tready) begin
      if (out_busy && m_tdest != out_dest) begin
        $display("CHECK FAILED m_tdest expected 0x%h got 0x%h", out_dest, m_tdest);
        error_count++;
      end
      if (exp_q[m_tdest].size() == 0) begin
        $display("extra output beat on dest %0d at %0t, no frame expected", m_tdest, $time);
        error_count++;
      end else begin
        beat = exp_q[m_tdest].pop_front();
        if (m_tdata != beat[`SW_DATA_WIDTH-1:0]) begin
          $display("CHECK FAILED m_tdata expected 0x%h got 0x%h",
                   beat[`SW_DATA_WIDTH-1:0], m_tdata);
          error_count++;
        end
        if (m_tlast != beat[`SW_DATA_WIDTH]) begin
          $display("CHECK FAILED m_tlast expected 0x%h got 0x%h", beat[`SW_DATA_WIDTH], m_tlast);
          error_count++;
        end
      end
      out_busy = !m_tlast;
      out_dest = m_tdest;
      if (m_tlast) frames_out++;
    end
  endtask

  function automatic logic queues_empty();
    for (int p = 0; p < PORTS; p++) begin
      if (exp_q[p].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic final_report();
    for (int p = 0; p < PORTS; p++) begin
      if (good_pulses[p] != good_frames[p]) begin
        $display("port %0d gave %0d good-frame pulses but %0d frames were expected",
                 p, good_pulses[p], good_frames[p]);
        error_count++;
      end
      if (exp_q[p].size() != 0) begin
        $display("%0d expected beats never came out on dest %0d", exp_q[p].size(), p);
        error_count++;
      end
    end
    $display("checker: %0d errors, %0d frames out, %0d frames dropped",
             error_count, frames_out, frames_dropped);
    report_done = 1'b1;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < PORTS; p++) begin
        exp_q[p].delete();
        held_fill[p]   = 0;
        good_frames[p] = 0;
        good_pulses[p] = 0;
      end
      in_beats.delete();
      exp_ovf        = '0;
      exp_bad        = '0;
      exp_good       = '0;
      frames_out     = 0;
      frames_dropped = 0;
      out_busy       = 1'b0;
      stall_seen     = 1'b0;
      error_count    = 0;
      report_done    = 1'b0;
      idle           = 1'b1;
    end else begin
      check_pulses("status_overflow", status_overflow, exp_ovf);
      check_pulses("status_bad_frame", status_bad_frame, exp_bad);
      check_pulses("status_good_frame", status_good_frame, exp_good);
      for (int p = 0; p < PORTS; p++) begin
        if (status_good_frame[p]) good_pulses[p]++;
      end
      exp_ovf  = '0;
      exp_bad  = '0;
      exp_good = '0;
      watch_input();
      watch_output();
      idle = !out_busy && queues_empty();
      if (finish_req && !report_done) final_report();
    end
  end

endmodule

// ==== verif/axis_switch_tb.sv ====
`timescale 1ns/100ps
`include "axis_switch_config.svh"

module axis_switch_tb;

  typedef struct packed {
    axis_switch_pkg::dest_t dest;
    logic [7:0]             len;
    axis_switch_pkg::data_t first;
    logic                   bad;
    logic                   hold;  // m_tready low while sent.
  } frame_row_t;

  localparam int NUM_FRAMES = 16;

  // --------------------
  // stimulus table
  // --------------------
  localparam frame_row_t FRAME_TABLE [NUM_FRAMES] = '{
    '{2'd1, 8'd6,  8'h10, 1'b0, 1'b1},
    '{2'd1, 8'd7,  8'h20, 1'b0, 1'b1},  // no room behind the first.
    '{2'd2, 8'd8,  8'h30, 1'b0, 1'b1},  // exactly fills the fifo.
    '{2'd2, 8'd4,  8'h40, 1'b0, 1'b1},
    '{2'd3, 8'd3,  8'h50, 1'b1, 1'b1},
    '{2'd0, 8'd4,  8'h60, 1'b0, 1'b0},
    '{2'd1, 8'd3,  8'h70, 1'b0, 1'b0},
    '{2'd2, 8'd9,  8'h80, 1'b0, 1'b0},  // longer than the fifo.
    '{2'd3, 8'd2,  8'h90, 1'b0, 1'b0},
    '{2'd0, 8'd4,  8'ha0, 1'b0, 1'b0},
    '{2'd1, 8'd2,  8'hb0, 1'b1, 1'b0},
    '{2'd2, 8'd5,  8'hc0, 1'b0, 1'b0},
    '{2'd3, 8'd1,  8'hd0, 1'b0, 1'b0},
    '{2'd1, 8'd3,  8'he0, 1'b0, 1'b0},
    '{2'd3, 8'd12, 8'hf0, 1'b0, 1'b0},
    '{2'd2, 8'd3,  8'h05, 1'b0, 1'b0}
  };

  logic                        clk;
  logic                        rst;
  axis_switch_pkg::data_t      s_tdata;
  logic                        s_tvalid;
  logic                        s_tready;
  logic                        s_tlast;
  axis_switch_pkg::dest_t      s_tdest;
  logic                        s_tuser;
  axis_switch_pkg::data_t      m_tdata;
  logic                        m_tvalid;
  logic                        m_tready;
  logic                        m_tlast;
  axis_switch_pkg::dest_t      m_tdest;
  axis_switch_pkg::port_mask_t status_overflow;
  axis_switch_pkg::port_mask_t status_bad_frame;
  axis_switch_pkg::port_mask_t status_good_frame;
  logic                        finish_req;
  logic                        idle;
  logic                        report_done;
  int                          error_count;

  logic                        hold_ready;
  logic                        taken;
  logic [31:0]                 lcg_state = 32'd26;

  tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

  axis_switch_top dut_i (
    .clk               (clk),
    .rst               (rst),
    .s_tdata           (s_tdata),
    .s_tvalid          (s_tvalid),
    .s_tready          (s_tready),
    .s_tlast           (s_tlast),
    .s_tdest           (s_tdest),
    .s_tuser           (s_tuser),
    .m_tdata           (m_tdata),
    .m_tvalid          (m_tvalid),
    .m_tready          (m_tready),
    .m_tlast           (m_tlast),
    .m_tdest           (m_tdest),
    .status_overflow   (status_overflow),
    .status_bad_frame  (status_bad_frame),
    .status_good_frame (status_good_frame)
  );

  axis_switch_checker checker_i (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int total_beats();
    int n;
    n = 0;
    for (int i = 0; i < NUM_FRAMES; i++) n += int'(FRAME_TABLE[i].len);
    return n;
  endfunction

  // one clock, then new m_tready a little after the edge.
  task automatic next_cycle();
    @(posedge clk);
    taken = s_tvalid && s_tready;
    #2;
    lcg_state = lcg_next(lcg_state);
    m_tready  = hold_ready ? 1'b0 : |lcg_state[17:16];
  endtask

  task automatic send_frame(input frame_row_t row);
    for (int b = 0; b < int'(row.len); b++) begin
      s_tvalid = 1'b1;
      s_tdata  = axis_switch_pkg::data_t'(int'(row.first) + b);
      s_tdest  = row.dest;
      s_tlast  = (b == int'(row.len) - 1);
      s_tuser  = row.bad && s_tlast;  // only the last beat marks it.
      do next_cycle(); while (!taken);
    end
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    s_tuser  = 1'b0;
  endtask

  task automatic wait_drain();
    do next_cycle(); while (!idle);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    frame_row_t row;
    s_tdata    = '0;
    s_tvalid   = 1'b0;
    s_tlast    = 1'b0;
    s_tdest    = '0;
    s_tuser    = 1'b0;
    m_tready   = 1'b0;
    finish_req = 1'b0;
    hold_ready = 1'b1;
    taken      = 1'b0;
    @(negedge rst);
    next_cycle();
    for (int r = 0; r < NUM_FRAMES; r++) begin
      row = FRAME_TABLE[r];
      if (!row.hold && hold_ready) begin
        hold_ready = 1'b0;
        wait_drain();  // held frames leave first.
      end
      hold_ready = row.hold;
      send_frame(row);
    end
    hold_ready = 1'b0;
    wait_drain();
    repeat (20) next_cycle();
    finish_req = 1'b1;
    do next_cycle(); while (!report_done);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog.
  initial begin
    int limit;
    limit = total_beats() * 20 + 200;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/axis_switch_pkg.sv
verilog/axis_dest_demux.sv
verilog/axis_frame_fifo.sv
verilog/axis_rr_mux.sv
verilog/axis_switch_top.sv
verif/tb_clock_gen.sv
verif/axis_switch_checker.sv
verif/axis_switch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= axis_switch_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
PASS_MSG  ?= Simulation passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
